//--- hw/cfg_scan_pkg.sv
/* Shared chain sizes and controller state encoding for the configuration scan subsystem.
   Modules import it inside their body or refer to it by scoped name in their header. */

package cfg_scan_pkg;

  // Default forward beads in one sector
  parameter int FW_BEAD_LENGTH_DEF = 8;

  // Default reverse beads in one sector
  parameter int RV_BEAD_LENGTH_DEF = 8;

  // Default number of sector bead buses in the loop
  parameter int SECTOR_COUNT_DEF = 2;

  // Controller sequence
  typedef enum logic [2:0] {
    IDLE,
    CAPTURE,
    SHIFT,
    UPDATE,
    CLEAR
  } cfg_state_t;

endpackage

//--- hw/cfg_bead.sv
/* One configuration bead: a shift flop that can capture the applied value,
   and an update flop that drives the bead's parallel output. */

`timescale 1ns/1ns

module cfg_bead (
  input  logic scan_clk,
  input  logic rst_n,
  input  logic scan_data_in,
  input  logic capture,
  input  logic update,
  input  logic clr_n,
  output logic scan_data_out,
  output logic bead_val
);

  logic shift_q;
  logic upd_q;

  // Shift stage, reloaded from the applied value on capture
  always_ff @(posedge scan_clk)
  begin
    if (capture)
      shift_q <= upd_q;
    else
      shift_q <= scan_data_in;
  end

  // Applied value only moves on update or clear
  always_ff @(posedge scan_clk)
  begin
    if (!rst_n || !clr_n)
      upd_q <= 1'b0;
    else if (update)
      upd_q <= shift_q;
  end

  assign scan_data_out = shift_q;
  assign bead_val      = upd_q;

endmodule

//--- hw/cfg_bead_bus.sv
/* Bead bus of one sector: a forward and a reverse bead segment on a shared control set.
   Control is passed on unchanged to the next sector in the loop. */

`timescale 1ns/1ns

module cfg_bead_bus #(
  parameter int FW_BEAD_LENGTH = cfg_scan_pkg::FW_BEAD_LENGTH_DEF,
  parameter int RV_BEAD_LENGTH = cfg_scan_pkg::RV_BEAD_LENGTH_DEF
) (
  // Shared control
  input  logic                      scan_clk,
  input  logic                      rst_n,
  input  logic                      capture,
  input  logic                      update,
  input  logic                      clr_n,

  // Forward path
  input  logic                      scan_data_in_fw,
  output logic                      scan_data_out_fw,
  output logic [FW_BEAD_LENGTH-1:0] bead_val_fw,

  // Reverse path
  input  logic                      scan_data_in_rv,
  output logic                      scan_data_out_rv,
  output logic [RV_BEAD_LENGTH-1:0] bead_val_rv,

  // Control towards the next sector
  output logic                      capture_out,
  output logic                      update_out,
  output logic                      clr_n_out
);

  logic [FW_BEAD_LENGTH:0] fw_link;
  logic [RV_BEAD_LENGTH:0] rv_link;

  assign capture_out = capture;
  assign update_out  = update;
  assign clr_n_out   = clr_n;

  assign fw_link[0] = scan_data_in_fw;
  assign rv_link[0] = scan_data_in_rv;

  // Forward segment, bead 0 sits next to the input
  for (genvar i = 0; i < FW_BEAD_LENGTH; i++)
  begin : g_fw
    cfg_bead u_bead (
      .scan_clk      (scan_clk),
      .rst_n         (rst_n),
      .scan_data_in  (fw_link[i]),
      .capture       (capture),
      .update        (update),
      .clr_n         (clr_n),
      .scan_data_out (fw_link[i+1]),
      .bead_val      (bead_val_fw[i])
    );
  end

  // Reverse segment
  for (genvar j = 0; j < RV_BEAD_LENGTH; j++)
  begin : g_rv
    cfg_bead u_bead (
      .scan_clk      (scan_clk),
      .rst_n         (rst_n),
      .scan_data_in  (rv_link[j]),
      .capture       (capture),
      .update        (update),
      .clr_n         (clr_n),
      .scan_data_out (rv_link[j+1]),
      .bead_val      (bead_val_rv[j])
    );
  end

  // No retiming at the segment ends, one bead is one cycle
  assign scan_data_out_fw = fw_link[FW_BEAD_LENGTH];
  assign scan_data_out_rv = rv_link[RV_BEAD_LENGTH];

endmodule

//--- hw/cfg_scan_ctrl.sv
/* Scan sequencer: runs capture, shift and update for a host load, or a clear,
   and returns the previously applied word as readback with a done strobe. */

`timescale 1ns/1ns

module cfg_scan_ctrl #(
  parameter int TOTAL_LEN = 32
) (
  input  logic                 scan_clk,
  input  logic                 rst_n,

  // Host side
  input  logic                 load,
  input  logic                 clear,
  input  logic [TOTAL_LEN-1:0] wr_data,
  output logic                 busy,
  output logic                 done,
  output logic [TOTAL_LEN-1:0] rd_data,

  // Chain side
  input  logic                 scan_in,
  output logic                 scan_data,
  output logic                 capture,
  output logic                 update,
  output logic                 clr_n
);

  import cfg_scan_pkg::*;

  localparam int CNT_W = (TOTAL_LEN > 1) ? $clog2(TOTAL_LEN) : 1;

  cfg_state_t           state_q;
  logic [CNT_W-1:0]     cnt_q;
  logic                 done_q;
  logic [TOTAL_LEN-1:0] wr_sh_q;
  logic [TOTAL_LEN-1:0] rd_sh_q;
  logic [TOTAL_LEN-1:0] rd_data_q;

  always_ff @(posedge scan_clk)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      case (state_q)
        IDLE:
        begin
          // Clear wins when both strobes arrive together
          if (clear)
            state_q <= CLEAR;
          else if (load)
            state_q <= CAPTURE;
        end
        CAPTURE:
        begin
          cnt_q   <= '0;
          state_q <= SHIFT;
        end
        SHIFT:
        begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == CNT_W'(TOTAL_LEN - 1))
            state_q <= UPDATE;
        end
        UPDATE:
        begin
          done_q  <= 1'b1;
          state_q <= IDLE;
        end
        CLEAR:
        begin
          done_q  <= 1'b1;
          state_q <= IDLE;
        end
        default:
          state_q <= IDLE;
      endcase
    end
  end

  // Outgoing word goes MSB first, the returning bits fill from the LSB side
  always_ff @(posedge scan_clk)
  begin
    if (state_q == IDLE)
      wr_sh_q <= wr_data;
    else if (state_q == SHIFT)
      wr_sh_q <= {wr_sh_q[TOTAL_LEN-2:0], 1'b0};

    if (state_q == SHIFT)
      rd_sh_q <= {rd_sh_q[TOTAL_LEN-2:0], scan_in};

    if (state_q == UPDATE)
      rd_data_q <= rd_sh_q;
    else if (state_q == CLEAR)
      rd_data_q <= '0;
  end

  assign busy      = (state_q != IDLE);
  assign capture   = (state_q == CAPTURE);
  assign update    = (state_q == UPDATE);
  assign clr_n     = (state_q != CLEAR);
  assign scan_data = wr_sh_q[TOTAL_LEN-1];
  assign done      = done_q;
  assign rd_data   = rd_data_q;

endmodule

//--- hw/cfg_scan_top.sv
/* Configuration scan top level: the controller and the sector bead buses closed into one loop.
   Forward segments run in sector order, reverse segments come back in reverse order. */

`timescale 1ns/1ns

module cfg_scan_top #(
  parameter int FW_BEAD_LENGTH = cfg_scan_pkg::FW_BEAD_LENGTH_DEF,
  parameter int RV_BEAD_LENGTH = cfg_scan_pkg::RV_BEAD_LENGTH_DEF,
  parameter int SECTOR_COUNT   = cfg_scan_pkg::SECTOR_COUNT_DEF,
  localparam int TOTAL_LEN     = SECTOR_COUNT * (FW_BEAD_LENGTH + RV_BEAD_LENGTH)
) (
  input  logic                 scan_clk,
  input  logic                 rst_n,
  input  logic                 load,
  input  logic                 clear,
  input  logic [TOTAL_LEN-1:0] wr_data,
  output logic                 busy,
  output logic                 done,
  output logic [TOTAL_LEN-1:0] rd_data,
  output logic [TOTAL_LEN-1:0] cfg_val
);

  // Index s is the entry point of sector s
  logic [SECTOR_COUNT:0] fw_link;
  logic [SECTOR_COUNT:0] rv_link;
  logic [SECTOR_COUNT:0] capture_link;
  logic [SECTOR_COUNT:0] update_link;
  logic [SECTOR_COUNT:0] clr_n_link;

  cfg_scan_ctrl #(
    .TOTAL_LEN (TOTAL_LEN)
  ) u_cfg_scan_ctrl (
    .scan_clk  (scan_clk),
    .rst_n     (rst_n),
    .load      (load),
    .clear     (clear),
    .wr_data   (wr_data),
    .scan_in   (rv_link[0]),
    .busy      (busy),
    .done      (done),
    .rd_data   (rd_data),
    .scan_data (fw_link[0]),
    .capture   (capture_link[0]),
    .update    (update_link[0]),
    .clr_n     (clr_n_link[0])
  );

  // Turnaround at the far end of the loop
  assign rv_link[SECTOR_COUNT] = fw_link[SECTOR_COUNT];

  for (genvar s = 0; s < SECTOR_COUNT; s++)
  begin : g_sector
    cfg_bead_bus #(
      .FW_BEAD_LENGTH (FW_BEAD_LENGTH),
      .RV_BEAD_LENGTH (RV_BEAD_LENGTH)
    ) u_cfg_bead_bus (
      .scan_clk         (scan_clk),
      .rst_n            (rst_n),
      .capture          (capture_link[s]),
      .update           (update_link[s]),
      .clr_n            (clr_n_link[s]),
      .scan_data_in_fw  (fw_link[s]),
      .scan_data_out_fw (fw_link[s+1]),
      .bead_val_fw      (cfg_val[s*FW_BEAD_LENGTH +: FW_BEAD_LENGTH]),
      .scan_data_in_rv  (rv_link[s+1]),
      .scan_data_out_rv (rv_link[s]),
      .bead_val_rv      (cfg_val[SECTOR_COUNT*FW_BEAD_LENGTH +
                                 (SECTOR_COUNT-1-s)*RV_BEAD_LENGTH +: RV_BEAD_LENGTH]),
      .capture_out      (capture_link[s+1]),
      .update_out       (update_link[s+1]),
      .clr_n_out        (clr_n_link[s+1])
    );
  end

endmodule

//--- verification/tb_clk_gen.sv
/* Testbench clock and reset source for the configuration scan testbench.
   Reset is released on a rising edge after RESET_CYCLES cycles. */

`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- verification/cfg_scan_tb.sv
/* Testbench for the configuration scan top level: random loads and clears from an LFSR,
   stray strobes while busy, all checked against a model of the applied word. */

`timescale 1ns/1ns

module cfg_scan_tb;

  import cfg_scan_pkg::*;

  localparam int TOTAL_LEN = SECTOR_COUNT_DEF * (FW_BEAD_LENGTH_DEF + RV_BEAD_LENGTH_DEF);
  localparam int NUM_OPS   = 28;
  localparam int WATCHDOG_CYCLES = 40 * (TOTAL_LEN + 10);

  logic                 clk;
  logic                 rst_n;
  logic                 load;
  logic                 clear;
  logic [TOTAL_LEN-1:0] wr_data;
  logic                 busy;
  logic                 done;
  logic [TOTAL_LEN-1:0] rd_data;
  logic [TOTAL_LEN-1:0] cfg_val;

  logic [31:0]          lfsr;
  logic [TOTAL_LEN-1:0] model_word;
  int                   errors;
  int                   checks;

  tb_clk_gen #(.PERIOD_NS (4), .RESET_CYCLES (3)) u_tb_clk_gen (.clk (clk), .rst_n (rst_n));

  cfg_scan_top #(
    .FW_BEAD_LENGTH (FW_BEAD_LENGTH_DEF),
    .RV_BEAD_LENGTH (RV_BEAD_LENGTH_DEF),
    .SECTOR_COUNT   (SECTOR_COUNT_DEF)
  ) u_cfg_scan_top (
    .scan_clk (clk),
    .rst_n    (rst_n),
    .load     (load),
    .clear    (clear),
    .wr_data  (wr_data),
    .busy     (busy),
    .done     (done),
    .rd_data  (rd_data),
    .cfg_val  (cfg_val)
  );

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      val  = (val << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic rand_word(output logic [TOTAL_LEN-1:0] w);
    w = '0;
    for (int i = 0; i < TOTAL_LEN; i++)
    begin
      w    = {w[TOTAL_LEN-2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check_word(input string name, input logic [TOTAL_LEN-1:0] exp,
                            input logic [TOTAL_LEN-1:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    assert (act === exp)
    else
    begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    assert (act == exp)
    else
    begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  // One host operation, with an optional stray strobe driven after cycle stray_cycle
  task automatic run_op(input logic is_clear, input logic [TOTAL_LEN-1:0] data,
                        input logic stray_en, input logic stray_clear, input int stray_cycle,
                        input logic [TOTAL_LEN-1:0] stray_data);
    int                   cycle;
    logic                 got_done;
    logic [TOTAL_LEN-1:0] exp_val;
    cycle    = 0;
    got_done = 1'b0;
    exp_val  = is_clear ? '0 : data;
    @(posedge clk);
    load    <= !is_clear;
    clear   <= is_clear;
    wr_data <= data;
    @(negedge clk);
    while (!got_done && cycle <= TOTAL_LEN + 10)
    begin
      @(posedge clk);
      if (stray_en && cycle == stray_cycle)
      begin
        load    <= !stray_clear;
        clear   <= stray_clear;
        wr_data <= stray_data;
      end
      else
      begin
        load  <= 1'b0;
        clear <= 1'b0;
      end
      @(negedge clk);
      cycle++;
      if (done)
        got_done = 1'b1;
      else
      begin
        check_bit("busy_during_op", 1'b1, busy);
        check_word("hold_while_busy", model_word, cfg_val);
      end
    end
    checks++;
    assert (got_done)
    else
    begin
      $display("done never arrived within %0d cycles of the strobe", TOTAL_LEN + 10);
      errors++;
    end
    check_count(is_clear ? "clear_latency" : "load_latency",
                is_clear ? 2 : TOTAL_LEN + 3, cycle);
    check_word(is_clear ? "clear_readback" : "readback",
               is_clear ? '0 : model_word, rd_data);
    check_word(is_clear ? "clear_value" : "load_value", exp_val, cfg_val);
    check_bit("busy_at_done", 1'b0, busy);
    model_word = exp_val;
    @(negedge clk);
    check_bit("done_pulse", 1'b0, done);
  endtask

  initial
  begin
    logic [TOTAL_LEN-1:0] data;
    logic [TOTAL_LEN-1:0] stray_data;
    int                   sel;
    int                   stray_en;
    int                   stray_kind;
    int                   cyc;
    lfsr       = 32'h15a1;
    model_word = '0;
    errors     = 0;
    checks     = 0;
    load       = 1'b0;
    clear      = 1'b0;
    wr_data    = '0;
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_word("reset_cfg_val", '0, cfg_val);
    check_bit("reset_busy", 1'b0, busy);
    check_bit("reset_done", 1'b0, done);

    rand_word(data);
    run_op(1'b0, data, 1'b0, 1'b0, 0, '0);
    for (int op = 0; op < NUM_OPS; op++)
    begin
      rand_bits(3, sel);
      rand_bits(1, stray_en);
      rand_bits(1, stray_kind);
      rand_bits(5, cyc);
      rand_word(data);
      rand_word(stray_data);
      // Roughly one clear in eight, stray strobes only ride on loads
      run_op(sel == 0, data, stray_en == 1 && sel != 0, stray_kind == 1,
             1 + cyc % TOTAL_LEN, stray_data);
    end

    // Clear followed by a load that must read back zero
    run_op(1'b1, '0, 1'b0, 1'b0, 0, '0);
    rand_word(data);
    run_op(1'b0, data, 1'b0, 1'b0, 0, '0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYCLES);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- cfg_scan.f
hw/cfg_scan_pkg.sv
hw/cfg_bead.sv
hw/cfg_bead_bus.sv
hw/cfg_scan_ctrl.sv
hw/cfg_scan_top.sv
verification/tb_clk_gen.sv
verification/cfg_scan_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the configuration scan testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns \
  -f cfg_scan.f \
  --top-module cfg_scan_tb \
  -o cfg_scan_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/cfg_scan_sim)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Verification passed" <<< "$sim_out"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
